// File: source/squash_defines.svh
// ----------------------------------------
// Build-time sizes for the squash unit
// SQUASH_NUM_SRC must be even and >= 2
// ----------------------------------------

`ifndef SQUASH_DEFINES_SVH
`define SQUASH_DEFINES_SVH

// ----------------------------------------
// Source count
// ----------------------------------------

// Split evenly into two arbiter groups
`define SQUASH_NUM_SRC 4

// ----------------------------------------
// Field widths
// ----------------------------------------

// Sequence counter wraps at 2**SQUASH_SEQ_BITS
`define SQUASH_SEQ_BITS 5

// Redirect address width
`define SQUASH_TARGET_BITS 32

`endif

// File: source/squash_pkg.sv
// ----------------------------------------
// Types shared by the squash unit blocks
// Widths come from squash_defines.svh
// ----------------------------------------

package squash_pkg;

  `include "squash_defines.svh"

  // ----------------------------------------
  // Vector types
  // ----------------------------------------

  // Instruction sequence number, wraps around
  typedef logic [`SQUASH_SEQ_BITS-1:0] seq_num_t;

  // Distance past the commit pointer, smaller is older
  typedef logic [`SQUASH_SEQ_BITS-1:0] age_t;

  // Redirect address
  typedef logic [`SQUASH_TARGET_BITS-1:0] target_t;

  // ----------------------------------------
  // Notifications
  // ----------------------------------------

  // One squash event, no acknowledge
  typedef struct packed {
    logic     val;
    seq_num_t seq_num;
    target_t  target;
  } squash_msg_t;

  // Commit event, only the sequence number is kept
  typedef struct packed {
    logic     val;
    seq_num_t seq_num;
  } commit_msg_t;

  // Age relative to the last committed instruction
  // Oldest in-flight instruction is commit_ptr + 1, age 0
  function automatic age_t seq_age(seq_num_t seq_num, seq_num_t commit_ptr);
    return age_t'(seq_num - commit_ptr - seq_num_t'(1));
  endfunction

endpackage

// File: source/commit_ptr_tracker.sv
// ----------------------------------------
// Tracks the last committed sequence number
// Resets to all ones so seq 0 is oldest
// ----------------------------------------

`timescale 1ns/1ns

module commit_ptr_tracker
  import squash_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  commit_msg_t commit,
  output seq_num_t    commit_ptr
);

  // ----------------------------------------
  // Pointer register
  // ----------------------------------------

  // Next value of the pointer
  seq_num_t ptr_next;

  // Load on a valid commit, otherwise hold
  always_comb begin
    ptr_next = commit_ptr;
    if (commit.val) begin
      ptr_next = commit.seq_num;
    end
  end

  // Last committed sequence number
  // All ones puts seq 0 at age 0
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      commit_ptr <= '1;
    end else begin
      commit_ptr <= ptr_next;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Unknown val would corrupt the age reference for
  // both arbiters and the combiner
  a_commit_val_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(commit.val)
  ) else $error("commit.val is unknown after reset");

  // Pointer itself must stay known once out of reset
  a_commit_ptr_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> !$isunknown(commit_ptr)
  ) else $error("commit_ptr is unknown after reset");

endmodule

// File: source/squash_group_arbiter.sv
// ----------------------------------------
// Oldest-first pick within one source group
// Purely combinational, ties go to low index
// ----------------------------------------

`timescale 1ns/1ns

module squash_group_arbiter
  import squash_pkg::*;
#(
  parameter int NUM_SRC = 2
)(
  input  squash_msg_t arb [NUM_SRC],
  input  seq_num_t    commit_ptr,
  output squash_msg_t winner
);

  // ----------------------------------------
  // Per-source age
  // ----------------------------------------

  // Age of every source, valid or not
  age_t src_age [NUM_SRC];

  // Valid bits gathered for the check below
  logic [NUM_SRC-1:0] src_val;

  for (genvar i = 0; i < NUM_SRC; i++) begin : g_age
    // Distance from the commit pointer
    assign src_age[i] = seq_age(arb[i].seq_num, commit_ptr);

    assign src_val[i] = arb[i].val;
  end

  // ----------------------------------------
  // Linear oldest-first scan
  // ----------------------------------------

  // Running best candidate
  squash_msg_t best;

  // Age of the running best
  age_t best_age;

  always_comb begin
    // Nothing valid yet
    best     = '0;
    best_age = '1;

    for (int i = 0; i < NUM_SRC; i++) begin
      // Take a valid source if nothing is held yet
      // Strictly older replaces the held one
      // Equal age keeps the lower index
      if (arb[i].val && (!best.val || (src_age[i] < best_age))) begin
        best     = arb[i];
        best_age = src_age[i];
      end
    end
  end

  // Val comes from the scan itself
  assign winner = best;

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Scan result against the plain OR of valids
  always_comb begin
    a_no_phantom_winner : assert final (!winner.val || (|src_val))
      else $error("group winner valid with no valid source");
  end

endmodule

// File: source/squash_combiner.sv
// ----------------------------------------
// Older of the two group winners, registered
// One cycle latency, accepts every cycle
// win_a wins ties
// ----------------------------------------

`timescale 1ns/1ns

module squash_combiner
  import squash_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  squash_msg_t win_a,
  input  squash_msg_t win_b,
  input  seq_num_t    commit_ptr,
  output squash_msg_t gnt
);

  // ----------------------------------------
  // Age compare
  // ----------------------------------------

  // Ages against the pointer before this edge
  age_t age_a;
  age_t age_b;

  assign age_a = seq_age(win_a.seq_num, commit_ptr);
  assign age_b = seq_age(win_b.seq_num, commit_ptr);

  // B only when strictly older or A is idle
  logic pick_b;

  assign pick_b = win_b.val && (!win_a.val || (age_b < age_a));

  // Selected message, val low when both idle
  squash_msg_t choice;

  assign choice = pick_b ? win_b : win_a;

  // ----------------------------------------
  // Grant register
  // ----------------------------------------

  // Payload loads every cycle, only val is reset
  always_ff @(posedge clk) begin
    gnt <= choice;
    if (!rst_n) begin
      gnt.val <= 1'b0;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // A grant needs a valid winner one cycle before
  a_gnt_has_source : assert property (
    @(posedge clk) disable iff (!rst_n)
    gnt.val |-> $past(win_a.val || win_b.val)
  ) else $error("gnt.val high with no valid winner in the previous cycle");

  // Single valid winner passes through untouched
  a_single_passthru : assert property (
    @(posedge clk) disable iff (!rst_n)
    (win_a.val ^ win_b.val) |=> (gnt == $past(win_a.val ? win_a : win_b))
  ) else $error("gnt differs from the only valid winner");

endmodule

// File: source/squash_unit.sv
// ----------------------------------------
// First-level squash unit, oldest squash wins
// Valid-only inputs, grant one cycle later
// Source count fixed by SQUASH_NUM_SRC
// ----------------------------------------

`timescale 1ns/1ns

`include "squash_defines.svh"

module squash_unit
  import squash_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  squash_msg_t arb [`SQUASH_NUM_SRC],
  input  commit_msg_t commit,
  output squash_msg_t gnt
);

  // Sources per group
  localparam int HALF = `SQUASH_NUM_SRC / 2;

  // Two equal groups only
  if ((`SQUASH_NUM_SRC < 2) || ((`SQUASH_NUM_SRC % 2) != 0)) begin : g_bad_cfg
    $error("SQUASH_NUM_SRC must be even and at least 2");
  end

  // ----------------------------------------
  // Source split
  // ----------------------------------------

  squash_msg_t arb_g0 [HALF];
  squash_msg_t arb_g1 [HALF];

  // Low half to g0, high half to g1
  for (genvar i = 0; i < HALF; i++) begin : g_split
    assign arb_g0[i] = arb[i];
    assign arb_g1[i] = arb[HALF + i];
  end

  // ----------------------------------------
  // Blocks
  // ----------------------------------------

  seq_num_t    commit_ptr;
  squash_msg_t win_g0;
  squash_msg_t win_g1;

  commit_ptr_tracker commit_ptr_tracker_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .commit     (commit),
    .commit_ptr (commit_ptr)
  );

  // Both groups arbitrate in parallel
  squash_group_arbiter #(
    .NUM_SRC (HALF)
  ) g0 (
    .arb        (arb_g0),
    .commit_ptr (commit_ptr),
    .winner     (win_g0)
  );

  squash_group_arbiter #(
    .NUM_SRC (HALF)
  ) g1 (
    .arb        (arb_g1),
    .commit_ptr (commit_ptr),
    .winner     (win_g1)
  );

  // g0 on win_a so it takes cross-group ties
  squash_combiner squash_combiner_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .win_a      (win_g0),
    .win_b      (win_g1),
    .commit_ptr (commit_ptr),
    .gnt        (gnt)
  );

endmodule

// File: verification/squash_unit_tb.sv
// ----------------------------------------
// Testbench for the squash unit
// Reference model tracks its own commit pointer
// Directed prologue, then 400 random cycles
// ----------------------------------------

`timescale 1ns/1ns

`include "squash_defines.svh"

module squash_unit_tb
  import squash_pkg::*;
;

  localparam int NUM_SRC        = `SQUASH_NUM_SRC;
  // Reset 8 + prologue ~20 + random 400 + tail, with margin
  localparam int TIMEOUT_CYCLES = 600;
  localparam int RANDOM_CYCLES  = 400;

  logic        clk;
  logic        rst_n;
  squash_msg_t arb [NUM_SRC];
  commit_msg_t commit;
  squash_msg_t gnt;

  // Stimulus staged before each drive
  squash_msg_t stim [NUM_SRC];

  // Model state
  seq_num_t    model_ptr;
  squash_msg_t exp_gnt;
  squash_msg_t ref_best;
  age_t        ref_best_age;

  logic        checks_on = 1'b0;
  int          errors = 0;
  int          cycle_cnt = 0;
  logic [31:0] rng_state = 32'h3507a180;

  squash_unit squash_unit_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .arb    (arb),
    .commit (commit),
    .gnt    (gnt)
  );

  // ----------------------------------------
  // Clock and timeout
  // ----------------------------------------

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    checks_on <= 1'b1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // LCG step, full 32-bit state
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // seq - ptr - 1 mod 2**n, same as seq + ~ptr
  function automatic age_t ref_age(seq_num_t seq, seq_num_t ptr);
    return age_t'(seq + ~ptr);
  endfunction

  task automatic clear_stim();
    for (int i = 0; i < NUM_SRC; i++) begin
      stim[i] = '0;
    end
  endtask

  task automatic set_src(int idx, seq_num_t seq, target_t tgt);
    stim[idx].val     = 1'b1;
    stim[idx].seq_num = seq;
    stim[idx].target  = tgt;
  endtask

  // Drive staged sources plus optional commit at the next edge
  task automatic drive_cycle(logic c_val, seq_num_t c_seq);
    @(posedge clk);
    arb            <= stim;
    commit.val     <= c_val;
    commit.seq_num <= c_seq;
    clear_stim();
  endtask

  task automatic random_cycle();
    logic [31:0] r;
    for (int i = 0; i < NUM_SRC; i++) begin
      r = next_rand();
      stim[i].val     = r[31];
      stim[i].seq_num = seq_num_t'(r >> 11);
      stim[i].target  = next_rand();
    end
    r = next_rand();
    // Commit in about a quarter of cycles
    drive_cycle(r[31:30] == 2'b00, seq_num_t'(r >> 7));
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Judged against the pointer before this edge
  always @(posedge clk) begin
    if (!rst_n) begin
      model_ptr <= '1;
      exp_gnt   <= '0;
    end else begin
      ref_best     = '0;
      ref_best_age = '1;
      // Strict compare keeps lowest index on ties
      for (int i = 0; i < NUM_SRC; i++) begin
        if (arb[i].val &&
            (!ref_best.val || (ref_age(arb[i].seq_num, model_ptr) < ref_best_age))) begin
          ref_best     = arb[i];
          ref_best_age = ref_age(arb[i].seq_num, model_ptr);
        end
      end
      exp_gnt <= ref_best;
      if (commit.val) begin
        model_ptr <= commit.seq_num;
      end
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  a_gnt_val : assert property (
    @(posedge clk) checks_on |-> (gnt.val === exp_gnt.val)
  ) else begin
    errors = errors + 1;
    $display("Fail at %0t ns: gnt.val expected %0b actual %0b",
             $time, $sampled(exp_gnt.val), $sampled(gnt.val));
  end

  a_gnt_seq : assert property (
    @(posedge clk) (checks_on && exp_gnt.val) |-> (gnt.seq_num === exp_gnt.seq_num)
  ) else begin
    errors = errors + 1;
    $display("Fail at %0t ns: gnt.seq_num expected %0d actual %0d",
             $time, $sampled(exp_gnt.seq_num), $sampled(gnt.seq_num));
  end

  a_gnt_target : assert property (
    @(posedge clk) (checks_on && exp_gnt.val) |-> (gnt.target === exp_gnt.target)
  ) else begin
    errors = errors + 1;
    $display("Fail at %0t ns: gnt.target expected %h actual %h",
             $time, $sampled(exp_gnt.target), $sampled(gnt.target));
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin
    rst_n  = 1'b0;
    commit = '0;
    // Valid squashes held through reset, none may reach gnt
    for (int i = 0; i < NUM_SRC; i++) begin
      arb[i]         = '0;
      arb[i].val     = 1'b1;
      arb[i].seq_num = seq_num_t'(i);
    end
    clear_stim();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    arb   <= stim;

    // Idle first cycle after reset
    drive_cycle(1'b0, '0);

    // One source at a time
    for (int i = 0; i < NUM_SRC; i++) begin
      set_src(i, seq_num_t'(i + 3), 32'h1000_0000 + i);
      drive_cycle(1'b0, '0);
    end

    // Several valid, oldest in the middle
    for (int i = 0; i < NUM_SRC; i++) begin
      set_src(i, seq_num_t'(9 - 2 * i), 32'h2000_0000 + i);
    end
    set_src(1, 5'd2, 32'h2000_00aa);
    drive_cycle(1'b0, '0);

    // Equal age across the two groups
    set_src(NUM_SRC / 2 - 1, 5'd4, 32'h3000_0001);
    set_src(NUM_SRC / 2, 5'd4, 32'h3000_0002);
    drive_cycle(1'b0, '0);

    // Pointer at 26, seq 29 beats seq 2
    drive_cycle(1'b1, 5'd26);
    set_src(0, 5'd2, 32'h4000_0000);
    set_src(NUM_SRC - 1, 5'd29, 32'h4000_0001);
    drive_cycle(1'b0, '0);

    // Commit of the highest seq, seq 0 now oldest
    drive_cycle(1'b1, '1);
    set_src(0, 5'd30, 32'h5000_0000);
    set_src(NUM_SRC - 1, 5'd0, 32'h5000_0001);
    drive_cycle(1'b0, '0);

    // Same-cycle commit uses the old pointer
    set_src(1, 5'd2, 32'h6000_0000);
    set_src(2, 5'd4, 32'h6000_0001);
    drive_cycle(1'b1, 5'd3);
    set_src(1, 5'd2, 32'h6000_0000);
    set_src(2, 5'd4, 32'h6000_0001);
    drive_cycle(1'b0, '0);

    // No source valid
    drive_cycle(1'b0, '0);

    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      random_cycle();
    end

    // Flush the last grants through the checks
    repeat (3) drive_cycle(1'b0, '0);
    @(posedge clk);
    #1;

    $display("Checks done after %0d cycles, error count %0d", cycle_cnt, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+source
source/squash_pkg.sv
source/commit_ptr_tracker.sv
source/squash_group_arbiter.sv
source/squash_combiner.sv
source/squash_unit.sv
verification/squash_unit_tb.sv
